// File: Makefile
# Verilator lint and simulation of the coincidence correlator

TOP := correlator_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module correlator_top -f filelist.f

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f filelist.f \
		--Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: filelist.f
logic/correlator_pkg.sv
logic/sample_delay_line.sv
logic/lag_correlator.sv
logic/integration_control.sv
logic/correlator_regs.sv
logic/correlator_top.sv
verif/correlator_tb.sv

// File: logic/correlator_pkg.sv
// ####################
// Correlator package
// Sizes, register map and reset values shared by the coincidence
// correlator blocks
// ####################

`default_nettype none

package correlator_pkg;

	// Detector lines and lag window
	localparam int num_inputs = 4;
	localparam int max_lag = 1;
	localparam int num_lags = 2 * max_lag + 1;
	localparam int num_taps = 2 * max_lag + 1; // Centre tap is the present sample

	// Baselines ordered (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
	localparam int num_baselines = num_inputs * (num_inputs - 1) / 2;
	localparam int num_counters = num_baselines * num_lags + num_inputs;

	localparam int count_width = 16;
	localparam int addr_width = 8;
	localparam int data_width = 16;

	// Register map
	localparam logic [addr_width-1:0] reg_control = 8'd0; // Enable mask in bits 3..0
	localparam logic [addr_width-1:0] reg_length = 8'd1;
	localparam logic [addr_width-1:0] reg_int_count = 8'd2; // Read only
	localparam logic [addr_width-1:0] reg_counter_base = 8'd16;

	// Values after reset
	localparam logic [num_inputs-1:0] reset_mask = '1;
	localparam logic [data_width-1:0] reset_length = 16'd16;

endpackage

`default_nettype wire

// File: logic/correlator_regs.sv
// ####################
// Correlator registers
// Holds the enable mask and integration length, counts completed
// integrations and serves the snapshot bank on the read port
// ####################

`default_nettype none

module correlator_regs (
	input  logic clk,
	input  logic reset,
	input  logic wr_en,
	input  logic rd_en,
	input  logic [correlator_pkg::addr_width-1:0] addr,
	input  logic [correlator_pkg::data_width-1:0] wr_data,
	output logic [correlator_pkg::data_width-1:0] rd_data,
	output logic [correlator_pkg::num_inputs-1:0] enable_mask,
	output logic [correlator_pkg::data_width-1:0] integration_length,
	output logic length_written,
	input  logic dump,
	input  logic [correlator_pkg::num_counters*correlator_pkg::count_width-1:0] snapshot_flat
);

	localparam int index_width = $clog2(correlator_pkg::num_counters);

	logic [correlator_pkg::num_counters-1:0][correlator_pkg::count_width-1:0] snapshot;
	logic [correlator_pkg::data_width-1:0] int_count;
	logic [correlator_pkg::addr_width-1:0] counter_offset;
	logic counter_hit;
	logic [correlator_pkg::data_width-1:0] read_value;

	assign snapshot = snapshot_flat;

	// The sample count in integration control restarts on this pulse
	assign length_written = wr_en && (addr == correlator_pkg::reg_length);

	always_ff @(posedge clk) begin
		if (!reset) begin
			enable_mask <= correlator_pkg::reset_mask;
			integration_length <= correlator_pkg::reset_length;
		end else if (wr_en) begin
			if (addr == correlator_pkg::reg_control) begin
				enable_mask <= wr_data[correlator_pkg::num_inputs-1:0];
			end
			if (addr == correlator_pkg::reg_length) begin
				integration_length <= wr_data;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			int_count <= '0;
		end else if (dump) begin
			int_count <= int_count + 1'b1; // One per completed integration
		end
	end

	assign counter_offset = addr - correlator_pkg::reg_counter_base;
	assign counter_hit = (addr >= correlator_pkg::reg_counter_base) &&
		(counter_offset < correlator_pkg::addr_width'(correlator_pkg::num_counters));

	// Unmapped addresses read as zero
	always_comb begin
		read_value = '0;
		if (addr == correlator_pkg::reg_control) begin
			read_value = correlator_pkg::data_width'(enable_mask);
		end else if (addr == correlator_pkg::reg_length) begin
			read_value = integration_length;
		end else if (addr == correlator_pkg::reg_int_count) begin
			read_value = int_count;
		end else if (counter_hit) begin
			read_value = snapshot[counter_offset[index_width-1:0]];
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			rd_data <= '0;
		end else if (rd_en) begin
			rd_data <= read_value; // Held until the next read
		end
	end

endmodule

`default_nettype wire

// File: logic/correlator_top.sv
// ####################
// Correlator top
// Four detector lines through delay lines into the lag correlator,
// with integration control and a register port for setup and readout
// ####################

`default_nettype none

module correlator_top (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [correlator_pkg::num_inputs-1:0] samples,
	input  logic                                sample_strobe,
	input  logic                                wr_en,
	input  logic                                rd_en,
	input  logic [correlator_pkg::addr_width-1:0] addr,
	input  logic [correlator_pkg::data_width-1:0] wr_data,
	output logic [correlator_pkg::data_width-1:0] rd_data,
	output logic                                integration_done
);

	logic [correlator_pkg::num_inputs*correlator_pkg::num_taps-1:0] taps_flat;
	logic [correlator_pkg::num_counters*correlator_pkg::count_width-1:0] snapshot_flat;
	logic [correlator_pkg::num_inputs-1:0] enable_mask;
	logic [correlator_pkg::data_width-1:0] integration_length;
	logic length_written;
	logic accumulate;
	logic dump;

	generate
		for (genvar n = 0; n < correlator_pkg::num_inputs; n++) begin : g_line
			sample_delay_line sample_delay_line_inst (
				.clk           (clk),
				.reset         (reset),
				.sample_strobe (sample_strobe),
				.sample        (samples[n]),
				.taps          (taps_flat[n*correlator_pkg::num_taps +: correlator_pkg::num_taps])
			);
		end
	endgenerate

	// The taps settle one edge after the strobe, so the count follows a cycle later
	always_ff @(posedge clk) begin
		if (!reset) begin
			accumulate <= 1'b0;
		end else begin
			accumulate <= sample_strobe;
		end
	end

	lag_correlator lag_correlator_inst (
		.clk           (clk),
		.reset         (reset),
		.taps_flat     (taps_flat),
		.enable_mask   (enable_mask),
		.accumulate    (accumulate),
		.dump          (dump),
		.snapshot_flat (snapshot_flat)
	);

	integration_control integration_control_inst (
		.clk                (clk),
		.reset              (reset),
		.accumulate         (accumulate),
		.integration_length (integration_length),
		.length_written     (length_written),
		.dump               (dump)
	);

	correlator_regs correlator_regs_inst (
		.clk                (clk),
		.reset              (reset),
		.wr_en              (wr_en),
		.rd_en              (rd_en),
		.addr               (addr),
		.wr_data            (wr_data),
		.rd_data            (rd_data),
		.enable_mask        (enable_mask),
		.integration_length (integration_length),
		.length_written     (length_written),
		.dump               (dump),
		.snapshot_flat      (snapshot_flat)
	);

	assign integration_done = dump;

endmodule

`default_nettype wire

// File: logic/integration_control.sv
// ####################
// Integration control
// Counts accumulated samples and raises dump on the sample that
// completes the programmed integration length
// ####################

`default_nettype none

module integration_control (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                accumulate,
	input  logic [correlator_pkg::data_width-1:0] integration_length,
	input  logic                                length_written,
	output logic                                dump
);

	logic [correlator_pkg::data_width-1:0] sample_count;
	logic length_active;

	assign length_active = (integration_length != '0); // Zero length stops dumping

	// Combinational so the dump lands on the completing sample itself
	assign dump = accumulate && length_active &&
		(sample_count == integration_length - 1'b1);

	always_ff @(posedge clk) begin
		if (!reset) begin
			sample_count <= '0;
		end else if (length_written || !length_active) begin
			sample_count <= '0; // A new length starts a fresh integration
		end else if (dump) begin
			sample_count <= '0;
		end else if (accumulate) begin
			sample_count <= sample_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: logic/lag_correlator.sv
// ####################
// Lag correlator
// Counts coincidences for every line pair at each lag, plus the ones
// on each single line, and copies the totals into a snapshot bank at
// the end of each integration
// ####################

`default_nettype none

module lag_correlator (
	input  logic clk,
	input  logic reset,
	input  logic [correlator_pkg::num_inputs*correlator_pkg::num_taps-1:0] taps_flat,
	input  logic [correlator_pkg::num_inputs-1:0] enable_mask,
	input  logic accumulate,
	input  logic dump,
	output logic [correlator_pkg::num_counters*correlator_pkg::count_width-1:0] snapshot_flat
);

	localparam int cross_counters = correlator_pkg::num_baselines * correlator_pkg::num_lags;

	logic [correlator_pkg::num_inputs-1:0][correlator_pkg::num_taps-1:0] line_taps;
	logic [correlator_pkg::num_inputs-1:0][correlator_pkg::num_taps-1:0] live_taps;
	logic [correlator_pkg::num_counters-1:0] hit;

	logic [correlator_pkg::num_counters-1:0][correlator_pkg::count_width-1:0] live_count;
	logic [correlator_pkg::num_counters-1:0][correlator_pkg::count_width-1:0] total_count;
	logic [correlator_pkg::num_counters-1:0][correlator_pkg::count_width-1:0] snapshot_count;

	assign line_taps = taps_flat;

	// A disabled line reads as all zeros
	generate
		for (genvar n = 0; n < correlator_pkg::num_inputs; n++) begin : g_mask
			assign live_taps[n] = line_taps[n] & {correlator_pkg::num_taps{enable_mask[n]}};
		end
	endgenerate

	// Cross products. Lag index l selects tap l of the second line, which is tap (1+L)
	// for lag L, against the centre tap of the first line
	generate
		for (genvar i = 0; i < correlator_pkg::num_inputs; i++) begin : g_first
			for (genvar j = i + 1; j < correlator_pkg::num_inputs; j++) begin : g_second
				localparam int baseline =
					i * correlator_pkg::num_inputs - (i * (i + 1)) / 2 + (j - i - 1);
				for (genvar l = 0; l < correlator_pkg::num_lags; l++) begin : g_lag
					assign hit[baseline * correlator_pkg::num_lags + l] =
						live_taps[i][correlator_pkg::max_lag] & live_taps[j][l];
				end
			end
		end
	endgenerate

	// Single-line counts sit after the cross counters
	generate
		for (genvar n = 0; n < correlator_pkg::num_inputs; n++) begin : g_single
			assign hit[cross_counters + n] = live_taps[n][correlator_pkg::max_lag];
		end
	endgenerate

	// Totals including this cycle's coincidences
	always_comb begin
		for (int c = 0; c < correlator_pkg::num_counters; c++) begin
			total_count[c] = live_count[c] +
				correlator_pkg::count_width'(hit[c] & accumulate);
		end
	end

	// The dump cycle's own increment lands in the snapshot while the live
	// counters restart, so the next integration starts clean
	always_ff @(posedge clk) begin
		if (!reset) begin
			live_count <= '0;
			snapshot_count <= '0;
		end else if (dump) begin
			snapshot_count <= total_count;
			live_count <= '0;
		end else if (accumulate) begin
			live_count <= total_count;
		end
	end

	assign snapshot_flat = snapshot_count;

endmodule

`default_nettype wire

// File: logic/sample_delay_line.sv
// ####################
// Sample delay line
// Keeps the recent samples of one detector line, shifting a new one in
// on every sample strobe
// ####################

`default_nettype none

module sample_delay_line (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              sample_strobe,
	input  logic                              sample,
	output logic [correlator_pkg::num_taps-1:0] taps
);

	// Tap 0 holds the newest sample, the highest tap the oldest
	always_ff @(posedge clk) begin
		if (!reset) begin
			taps <= '0;
		end else if (sample_strobe) begin
			taps <= {taps[correlator_pkg::num_taps-2:0], sample};
		end
	end

endmodule

`default_nettype wire

// File: verif/correlator_tb.sv
// ####################
// Correlator testbench
// Runs a table of LFSR sample bursts through the correlator and checks
// every snapshot, the done pulse and the register block against a
// software coincidence model
// ####################

`default_nettype none

module correlator_tb;

	localparam int num_rows = 5;
	localparam int period = 4;
	localparam int cross_counters = correlator_pkg::num_baselines * correlator_pkg::num_lags;

	logic clk;
	logic reset;
	logic [correlator_pkg::num_inputs-1:0] samples;
	logic sample_strobe;
	logic wr_en;
	logic rd_en;
	logic [correlator_pkg::addr_width-1:0] addr;
	logic [correlator_pkg::data_width-1:0] wr_data;
	logic [correlator_pkg::data_width-1:0] rd_data;
	logic integration_done;

	// Columns are enable mask, integration length, integrations, idle cycles between strobes
	int row_mask [num_rows] = '{15, 11, 15, 6, 15};
	int row_length [num_rows] = '{16, 12, 10, 7, 0};
	int row_runs [num_rows] = '{2, 2, 3, 2, 1};
	int row_gap [num_rows] = '{0, 0, 2, 1, 0};

	logic [31:0] lfsr = 32'h3b350291;
	logic [correlator_pkg::num_taps-1:0] history [correlator_pkg::num_inputs];
	int live_model [correlator_pkg::num_counters];
	int snap_model [correlator_pkg::num_counters];
	int samples_in_int;
	logic expect_done;
	int dumps_expected;
	int done_seen;
	int errors;
	int checks;

	correlator_top correlator_top_inst (
		.clk              (clk),
		.reset            (reset),
		.samples          (samples),
		.sample_strobe    (sample_strobe),
		.wr_en            (wr_en),
		.rd_en            (rd_en),
		.addr             (addr),
		.wr_data          (wr_data),
		.rd_data          (rd_data),
		.integration_done (integration_done)
	);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	function automatic int run_strobes(input int row);
		if (row_length[row] == 0) begin
			return 20; // Zero length gets a fixed burst that must not dump
		end
		return row_length[row];
	endfunction

	task automatic check_value(input string what, input int got, input int expected);
		checks++;
		if (got != expected) begin
			errors++;
			$display("[ERROR] %0t %s: got %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	// Galois LFSR, one step per bit
	function automatic logic next_random_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		return b;
	endfunction

	// One clock edge, then the done check and idle inputs for the next edge
	task automatic tick();
		@(posedge clk);
		#1;
		check_value("integration_done", int'(integration_done), int'(expect_done));
		if (integration_done) begin
			done_seen++;
		end
		expect_done = 1'b0;
		sample_strobe = 1'b0;
		wr_en = 1'b0;
		rd_en = 1'b0;
	endtask

	task automatic write_reg(input int a, input int d);
		addr = a;
		wr_data = d;
		wr_en = 1'b1;
		tick();
	endtask

	task automatic read_reg(input int a, output int d);
		addr = a;
		rd_en = 1'b1;
		tick();
		d = rd_data; // One cycle read latency
	endtask

	// Centre sample of the first line against tap (1+L) of the second for lag L
	task automatic model_sample(input logic [3:0] s, input logic [3:0] mask, input int length);
		int b;
		b = 0;
		for (int n = 0; n < correlator_pkg::num_inputs; n++) begin
			history[n] = {history[n][correlator_pkg::num_taps-2:0], s[n]};
		end
		for (int i = 0; i < correlator_pkg::num_inputs; i++) begin
			for (int j = i + 1; j < correlator_pkg::num_inputs; j++) begin
				for (int l = 0; l < correlator_pkg::num_lags; l++) begin
					if (mask[i] && mask[j] && history[i][1] && history[j][l]) begin
						live_model[b * correlator_pkg::num_lags + l]++;
					end
				end
				b++;
			end
		end
		for (int n = 0; n < correlator_pkg::num_inputs; n++) begin
			if (mask[n] && history[n][1]) begin
				live_model[cross_counters + n]++;
			end
		end
		if (length != 0) begin
			samples_in_int++;
			if (samples_in_int == length) begin
				snap_model = live_model; // Includes the completing sample
				foreach (live_model[c]) live_model[c] = 0;
				samples_in_int = 0;
				expect_done = 1'b1;
				dumps_expected++;
			end
		end
	endtask

	task automatic check_snapshot(input string label);
		int value;
		for (int c = 0; c < correlator_pkg::num_counters; c++) begin
			read_reg(correlator_pkg::reg_counter_base + c, value);
			check_value($sformatf("%s counter %0d", label, c), value, snap_model[c]);
		end
	endtask

	task automatic run_row(input int r);
		logic [3:0] mask;
		logic [3:0] s;
		int value;
		mask = row_mask[r];
		write_reg(correlator_pkg::reg_control, mask);
		write_reg(correlator_pkg::reg_length, row_length[r]);
		samples_in_int = 0; // The length write restarts the sample count
		for (int k = 0; k < row_runs[r]; k++) begin
			for (int t = 0; t < run_strobes(r); t++) begin
				for (int n = 0; n < correlator_pkg::num_inputs; n++) begin
					s[n] = next_random_bit();
				end
				samples = s;
				sample_strobe = 1'b1;
				model_sample(s, mask, row_length[r]);
				tick();
				if (t != run_strobes(r) - 1) begin
					repeat (row_gap[r]) tick();
				end
			end
			tick();
			tick();
			check_snapshot($sformatf("row %0d run %0d", r, k));
		end
		read_reg(correlator_pkg::reg_int_count, value);
		check_value($sformatf("row %0d reg_int_count", r), value, dumps_expected);
		check_value($sformatf("row %0d done pulses", r), done_seen, dumps_expected);
	endtask

	initial begin : watchdog
		int cycles;
		cycles = 200;
		for (int r = 0; r < num_rows; r++) begin
			cycles += row_runs[r] * (run_strobes(r) * (row_gap[r] + 1) + 40);
		end
		#(cycles * period);
		$display("Run timed out after %0d cycles before the test table finished", cycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin : stimulus
		int value;
		reset = 1'b0;
		samples = '0;
		sample_strobe = 1'b0;
		wr_en = 1'b0;
		rd_en = 1'b0;
		addr = '0;
		wr_data = '0;
		expect_done = 1'b0;
		dumps_expected = 0;
		done_seen = 0;
		errors = 0;
		checks = 0;
		samples_in_int = 0;
		foreach (history[n]) history[n] = '0;
		foreach (live_model[c]) begin
			live_model[c] = 0;
			snap_model[c] = 0;
		end

		repeat (8) @(posedge clk);
		#1;
		reset = 1'b1;

		read_reg(correlator_pkg::reg_control, value);
		check_value("reg_control after reset", value, 15);
		read_reg(correlator_pkg::reg_length, value);
		check_value("reg_length after reset", value, 16);
		read_reg(correlator_pkg::reg_int_count, value);
		check_value("reg_int_count after reset", value, 0);
		check_snapshot("after reset");

		for (int r = 0; r < num_rows; r++) begin
			run_row(r);
		end

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
